/* list.f */
verilog/decap_pkg.sv
verilog/pio_clk_div.sv
verilog/decap_pio_mem.sv
verilog/decap_pio.sv
verilog/decap_pio_top.sv
test/decap_pio_properties.sv
test/tb_decap_pio.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decap PIO testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_decap_pio \
	-f list.f \
	-o sim_tb_decap_pio

status=0
./obj_dir/sim_tb_decap_pio > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation FAILED" sim.log; then
	echo "Run failed, see sim.log."
	exit 1
fi

echo "Run finished, see sim.log."
exit 0

/* test/tb_decap_pio.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_decap_pio;

	// --------------------------------------------------
	// Constants, signals and the reference model.
	// --------------------------------------------------

	localparam int clk_div_ratio = 4;
	localparam int wait_limit    = 16 * clk_div_ratio; // Cycles before a wait gives up.
	localparam int n_random      = 200;

	logic                            clk;
	logic                            rst_n;
	logic                            reg_bs;
	logic                            reg_wr;
	logic                            reg_rd;
	logic [decap_pkg::pio_nbits-1:0] reg_addr;
	logic [decap_pkg::pio_nbits-1:0] reg_din;
	logic                            pio_ack;
	logic                            pio_rvalid;
	logic [decap_pkg::pio_nbits-1:0] pio_rdata;

	logic [31:0] model [4][64]; // Expected words, one row per memory.
	bit          model_valid [4][64];

	integer seed;
	int     err_count;
	int     check_count;

	decap_pio_top UUT (
		.clk(clk), .rst_n(rst_n), .reg_bs(reg_bs), .reg_wr(reg_wr), .reg_rd(reg_rd),
		.reg_addr(reg_addr), .reg_din(reg_din),
		.pio_ack(pio_ack), .pio_rvalid(pio_rvalid), .pio_rdata(pio_rdata));

	bind decap_pio decap_pio_properties u_properties (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div), .reg_addr(reg_addr),
		.reg_ms_rci_hash_table(reg_ms_rci_hash_table),
		.reg_ms_rci_value(reg_ms_rci_value),
		.reg_ms_ekey_hash_table(reg_ms_ekey_hash_table),
		.reg_ms_ekey_value(reg_ms_ekey_value),
		.pio_ack(pio_ack), .pio_rvalid(pio_rvalid));

	always #4 clk = ~clk;

	// --------------------------------------------------
	// Helpers.
	// --------------------------------------------------

	// Depth of each memory as set by the top level defaults.
	function automatic int mem_depth(input int sel);
		case (sel)
			0:       return 16;
			1:       return 32;
			2:       return 16;
			default: return 64;
		endcase
	endfunction

	function automatic logic [31:0] make_addr(input int sel, input int idx);
		logic [3:0]  code;
		logic [27:0] word;
		code = sel[3:0];
		word = idx[27:0];
		return {code, word};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			err_count++;
			$display("[FAIL] %0s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		assert (got === exp) else begin
			err_count++;
			$display("[FAIL] %0s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic wait_ack(input logic level, output bit ok);
		int cycles;
		cycles = 0;
		while (pio_ack !== level && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		ok = (pio_ack === level);
		assert (ok) else begin
			err_count++;
			$display("Timeout: pio_ack did not go %0s within %0d cycles.",
			         level ? "high" : "low", wait_limit);
		end
	endtask

	// Requests must not land on the edge where the slow tick is sampled.
	task automatic wait_free_slot();
		int cycles;
		cycles = 0;
		while (UUT.clk_div && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		assert (!UUT.clk_div) else begin
			err_count++;
			$display("Timeout: clk_div stayed high, no slot for a request.");
		end
	endtask

	task automatic issue_request(input bit is_write, input logic [31:0] addr,
	                             input logic [31:0] data, output bit ok);
		bit was_high;
		bit ok_low;
		wait_free_slot();
		reg_addr = addr;
		reg_din  = data;
		reg_wr   = is_write;
		reg_rd   = !is_write;
		was_high = pio_ack; // An old ack falls at the first tick.
		@(negedge clk);
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		ok_low = 1'b1;
		if (was_high)
			wait_ack(1'b0, ok_low);
		wait_ack(1'b1, ok);
		ok = ok & ok_low;
	endtask

	task automatic pio_write(input int sel, input int idx, input logic [31:0] data);
		bit ok;
		issue_request(1'b1, make_addr(sel, idx), data, ok);
		if (sel < 4) begin
			model[sel][idx % mem_depth(sel)]       = data;
			model_valid[sel][idx % mem_depth(sel)] = 1'b1;
		end
	endtask

	task automatic pio_read(input int sel, input int idx);
		bit ok;
		issue_request(1'b0, make_addr(sel, idx), 32'h0, ok);
		if (ok) begin
			check_flag("pio_rvalid", pio_rvalid, 1'b1);
			if (model_valid[sel][idx % mem_depth(sel)])
				check_value("pio_rdata", pio_rdata, model[sel][idx % mem_depth(sel)]);
		end
	endtask

	// An unmapped access gets a dummy ack that lasts one tick period.
	task automatic unmapped_access(input bit is_write, input int code);
		bit ok;
		int cycles;
		issue_request(is_write, make_addr(code, 3), $random(seed), ok);
		if (ok) begin
			check_flag("pio_rvalid", pio_rvalid, 1'b0);
			check_value("pio_rdata", pio_rdata, 32'h0);
			cycles = 0;
			while (pio_ack && cycles < wait_limit) begin
				@(negedge clk);
				cycles++;
			end
			assert (!pio_ack) else begin
				err_count++;
				$display("Timeout: dummy ack for code %0d never went low.", code);
			end
			check_value("dummy ack width", cycles, clk_div_ratio);
		end
	endtask

	// --------------------------------------------------
	// Directed tests.
	// --------------------------------------------------

	task automatic idle_after_reset();
		check_flag("pio_ack", pio_ack, 1'b0);
		check_flag("pio_rvalid", pio_rvalid, 1'b0);
	endtask

	task automatic each_memory_roundtrip();
		for (int sel = 0; sel < 4; sel++)
			pio_write(sel, sel + 3, 32'hd00d_0000 + 32'(sel * 32'h111));
		for (int sel = 0; sel < 4; sel++)
			pio_read(sel, sel + 3);
	endtask

	task automatic unmapped_codes();
		unmapped_access(1'b1, 4);
		unmapped_access(1'b0, 4);
		unmapped_access(1'b1, 15);
		unmapped_access(1'b0, 15);
		for (int sel = 0; sel < 4; sel++)
			pio_read(sel, sel + 3); // Mapped contents must be untouched.
	endtask

	task automatic index_wrap_around();
		for (int sel = 0; sel < 4; sel++) begin
			pio_write(sel, mem_depth(sel) + sel + 1, $random(seed));
			// A read of another word moves mem_rdata off the written word.
			pio_read(sel, sel + 3);
			pio_read(sel, sel + 1);
		end
	endtask

	task automatic random_traffic();
		logic [31:0] r;
		int          sel;
		int          idx;
		bit          is_write;
		for (int n = 0; n < n_random; n++) begin
			r        = $random(seed);
			sel      = int'(r[1:0]);
			idx      = int'(r[9:2]) % (2 * mem_depth(sel)); // Reaches past depth too.
			is_write = r[10];
			if (!model_valid[sel][idx % mem_depth(sel)])
				is_write = 1'b1;
			if (is_write)
				pio_write(sel, idx, $random(seed));
			else
				pio_read(sel, idx);
		end
	endtask

	// --------------------------------------------------
	// Main sequence.
	// --------------------------------------------------

	initial begin
		seed        = 32'hf7e5_68a1;
		err_count   = 0;
		check_count = 0;
		clk         = 1'b0;
		rst_n       = 1'b0;
		reg_bs      = 1'b0;
		reg_wr      = 1'b0;
		reg_rd      = 1'b0;
		reg_addr    = '0;
		reg_din     = '0;

		repeat (4) @(negedge clk);
		rst_n  = 1'b1;
		reg_bs = 1'b1;
		@(negedge clk);

		idle_after_reset();
		each_memory_roundtrip();
		unmapped_codes();
		index_wrap_around();
		random_traffic();

		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/decap_pio_properties.sv */
`timescale 1ns/10ps
`default_nettype none

// Checks on the PIO address decoder, bound into every decap_pio instance.
module decap_pio_properties (
	input logic                            clk,
	input logic                            rst_n,
	input logic                            clk_div,
	input logic [decap_pkg::pio_nbits-1:0] reg_addr,
	input logic                            reg_ms_rci_hash_table,
	input logic                            reg_ms_rci_value,
	input logic                            reg_ms_ekey_hash_table,
	input logic                            reg_ms_ekey_value,
	input logic                            pio_ack,
	input logic                            pio_rvalid
);

	logic [3:0]                                sel_vec;
	logic [decap_pkg::decr_mem_sel_nbits-1:0] sel_field;
	logic                                      sel_mapped;

	// Bit n of sel_vec belongs to select code n.
	assign sel_vec = {reg_ms_ekey_value, reg_ms_ekey_hash_table,
	                  reg_ms_rci_value, reg_ms_rci_hash_table};

	assign sel_field  = reg_addr[decap_pkg::decr_mem_sel_lsb +: decap_pkg::decr_mem_sel_nbits];
	assign sel_mapped = (sel_field <= decap_pkg::decr_ekey_value); // Codes 0 to 3.

	// --------------------------------------------------
	// Ack and read-valid move on the slow tick only.
	// --------------------------------------------------

	ack_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
		(pio_ack != $past(pio_ack)) |-> $past(clk_div))
		else $error("pio_ack changed on an edge without clk_div.");

	rvalid_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
		(pio_rvalid != $past(pio_rvalid)) |-> $past(clk_div))
		else $error("pio_rvalid changed on an edge without clk_div.");

	// --------------------------------------------------
	// Select decode.
	// --------------------------------------------------

	sel_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(sel_vec))
		else $error("More than one memory select is high.");

	sel_when_mapped: assert property (@(posedge clk) disable iff (!rst_n)
		(|sel_vec) == sel_mapped)
		else $error("Memory select does not follow the select field.");

	sel_matches_code: assert property (@(posedge clk) disable iff (!rst_n)
		sel_mapped |-> (sel_vec == (4'b0001 << sel_field[1:0])))
		else $error("Wrong memory selected for the select field.");

endmodule

`default_nettype wire

/* verilog/decap_pio_top.sv */
`timescale 1ns/10ps
`default_nettype none

// PIO side of the decapsulation block: the tick divider, the four lookup
// memories and the address decoder.
module decap_pio_top #(
	parameter int clk_div_ratio  = 4,
	parameter int rci_ht_depth   = 16,
	parameter int rci_val_depth  = 32,
	parameter int ekey_ht_depth  = 16,
	parameter int ekey_val_depth = 64
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            reg_bs,
	input  logic                            reg_wr,
	input  logic                            reg_rd,
	input  logic [decap_pkg::pio_nbits-1:0] reg_addr,
	input  logic [decap_pkg::pio_nbits-1:0] reg_din,
	output logic                            pio_ack,
	output logic                            pio_rvalid,
	output logic [decap_pkg::pio_nbits-1:0] pio_rdata
);

	// --------------------------------------------------
	// Interconnect.
	// --------------------------------------------------

	logic clk_div;

	logic reg_ms_rci_hash_table;
	logic reg_ms_rci_value;
	logic reg_ms_ekey_hash_table;
	logic reg_ms_ekey_value;

	logic rci_hash_table_mem_ack;
	logic rci_value_mem_ack;
	logic ekey_hash_table_mem_ack;
	logic ekey_value_mem_ack;

	logic [decap_pkg::pio_nbits-1:0] rci_hash_table_mem_rdata;
	logic [decap_pkg::pio_nbits-1:0] rci_value_mem_rdata;
	logic [decap_pkg::pio_nbits-1:0] ekey_hash_table_mem_rdata;
	logic [decap_pkg::pio_nbits-1:0] ekey_value_mem_rdata;

	// --------------------------------------------------
	// Instances.
	// --------------------------------------------------

	pio_clk_div #(.clk_div_ratio(clk_div_ratio)) u_clk_div (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div));

	decap_pio_mem #(.depth(rci_ht_depth)) u_rci_hash_table ( // RCI hash table.
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div), .reg_bs(reg_bs),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_ms(reg_ms_rci_hash_table),
		.reg_addr(reg_addr), .reg_din(reg_din),
		.mem_ack(rci_hash_table_mem_ack), .mem_rdata(rci_hash_table_mem_rdata));

	decap_pio_mem #(.depth(rci_val_depth)) u_rci_value ( // RCI value table.
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div), .reg_bs(reg_bs),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_ms(reg_ms_rci_value),
		.reg_addr(reg_addr), .reg_din(reg_din),
		.mem_ack(rci_value_mem_ack), .mem_rdata(rci_value_mem_rdata));

	decap_pio_mem #(.depth(ekey_ht_depth)) u_ekey_hash_table ( // EKEY hash table.
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div), .reg_bs(reg_bs),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_ms(reg_ms_ekey_hash_table),
		.reg_addr(reg_addr), .reg_din(reg_din),
		.mem_ack(ekey_hash_table_mem_ack), .mem_rdata(ekey_hash_table_mem_rdata));

	decap_pio_mem #(.depth(ekey_val_depth)) u_ekey_value ( // EKEY value table.
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div), .reg_bs(reg_bs),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_ms(reg_ms_ekey_value),
		.reg_addr(reg_addr), .reg_din(reg_din),
		.mem_ack(ekey_value_mem_ack), .mem_rdata(ekey_value_mem_rdata));

	decap_pio u_decap_pio (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
		.rci_hash_table_mem_ack(rci_hash_table_mem_ack),
		.rci_value_mem_ack(rci_value_mem_ack),
		.ekey_hash_table_mem_ack(ekey_hash_table_mem_ack),
		.ekey_value_mem_ack(ekey_value_mem_ack),
		.rci_hash_table_mem_rdata(rci_hash_table_mem_rdata),
		.rci_value_mem_rdata(rci_value_mem_rdata),
		.ekey_hash_table_mem_rdata(ekey_hash_table_mem_rdata),
		.ekey_value_mem_rdata(ekey_value_mem_rdata),
		.reg_ms_rci_hash_table(reg_ms_rci_hash_table),
		.reg_ms_rci_value(reg_ms_rci_value),
		.reg_ms_ekey_hash_table(reg_ms_ekey_hash_table),
		.reg_ms_ekey_value(reg_ms_ekey_value),
		.pio_ack(pio_ack), .pio_rvalid(pio_rvalid), .pio_rdata(pio_rdata));

endmodule

`default_nettype wire

/* verilog/decap_pio.sv */
`timescale 1ns/10ps
`default_nettype none

// Address decoder of the decapsulation PIO space. The select field of
// reg_addr picks one of four memories. Ack and read-valid are sampled on
// the slow tick only. Unmapped addresses get a dummy ack pulse.
module decap_pio (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            clk_div,
	input  logic                            reg_wr,
	input  logic                            reg_rd,
	input  logic [decap_pkg::pio_nbits-1:0] reg_addr,

	input  logic                            rci_hash_table_mem_ack,
	input  logic                            rci_value_mem_ack,
	input  logic                            ekey_hash_table_mem_ack,
	input  logic                            ekey_value_mem_ack,

	input  logic [decap_pkg::pio_nbits-1:0] rci_hash_table_mem_rdata,
	input  logic [decap_pkg::pio_nbits-1:0] rci_value_mem_rdata,
	input  logic [decap_pkg::pio_nbits-1:0] ekey_hash_table_mem_rdata,
	input  logic [decap_pkg::pio_nbits-1:0] ekey_value_mem_rdata,

	output logic                            reg_ms_rci_hash_table,
	output logic                            reg_ms_rci_value,
	output logic                            reg_ms_ekey_hash_table,
	output logic                            reg_ms_ekey_value,

	output logic                            pio_ack,
	output logic                            pio_rvalid,
	output logic [decap_pkg::pio_nbits-1:0] pio_rdata
);

	// --------------------------------------------------
	// Local signals.
	// --------------------------------------------------

	decap_pkg::decr_mem_e sel_code; // Select field of the address.

	logic pio_ack_nxt;
	logic pio_rvalid_nxt;
	logic addr_mapped;

	logic dummy_pending; // Unmapped request seen, waiting for T1.
	logic dummy_ack;     // Dummy ack, sampled into pio_ack at T2.

	assign sel_code = decap_pkg::decr_mem_e'(
		reg_addr[decap_pkg::decr_mem_sel_lsb +: decap_pkg::decr_mem_sel_nbits]);

	// --------------------------------------------------
	// Decode and read-data mux.
	// --------------------------------------------------

	always_comb begin
		pio_ack_nxt            = 1'b0;
		pio_rvalid_nxt         = 1'b0;
		pio_rdata              = '0;
		addr_mapped            = 1'b1;
		reg_ms_rci_hash_table  = 1'b0;
		reg_ms_rci_value       = 1'b0;
		reg_ms_ekey_hash_table = 1'b0;
		reg_ms_ekey_value      = 1'b0;

		case (sel_code)
			decap_pkg::decr_rci_hash_table: begin
				pio_ack_nxt           = rci_hash_table_mem_ack;
				pio_rvalid_nxt        = 1'b1;
				pio_rdata             = rci_hash_table_mem_rdata;
				reg_ms_rci_hash_table = 1'b1;
			end
			decap_pkg::decr_rci_value: begin
				pio_ack_nxt      = rci_value_mem_ack;
				pio_rvalid_nxt   = 1'b1;
				pio_rdata        = rci_value_mem_rdata;
				reg_ms_rci_value = 1'b1;
			end
			decap_pkg::decr_ekey_hash_table: begin
				pio_ack_nxt            = ekey_hash_table_mem_ack;
				pio_rvalid_nxt         = 1'b1;
				pio_rdata              = ekey_hash_table_mem_rdata;
				reg_ms_ekey_hash_table = 1'b1;
			end
			decap_pkg::decr_ekey_value: begin
				pio_ack_nxt       = ekey_value_mem_ack;
				pio_rvalid_nxt    = 1'b1;
				pio_rdata         = ekey_value_mem_rdata;
				reg_ms_ekey_value = 1'b1;
			end
			default: begin
				pio_ack_nxt = dummy_ack; // Nobody answers, so fake it.
				addr_mapped = 1'b0;
			end
		endcase
	end

	// --------------------------------------------------
	// Registered acknowledge.
	// --------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pio_ack       <= 1'b0;
			pio_rvalid    <= 1'b0;
			dummy_pending <= 1'b0;
			dummy_ack     <= 1'b0;
		end else begin
			if (clk_div) begin
				pio_ack    <= pio_ack_nxt;
				pio_rvalid <= pio_rvalid_nxt;
				dummy_ack  <= dummy_pending; // Two-stage pulse, one tick wide.
			end

			if ((reg_rd | reg_wr) && !addr_mapped)
				dummy_pending <= 1'b1;
			else if (clk_div)
				dummy_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/decap_pio_mem.sv */
`timescale 1ns/10ps
`default_nettype none

// One word memory reachable over the PIO bus. A selected request is
// captured at once and carried out on the next clk_div tick, which also
// raises mem_ack. The ack then stays high until the next request.
module decap_pio_mem #(
	parameter int depth = 16
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            clk_div,
	input  logic                            reg_bs,
	input  logic                            reg_wr,
	input  logic                            reg_rd,
	input  logic                            reg_ms,
	input  logic [decap_pkg::pio_nbits-1:0] reg_addr,
	input  logic [decap_pkg::pio_nbits-1:0] reg_din,
	output logic                            mem_ack,
	output logic [decap_pkg::pio_nbits-1:0] mem_rdata
);

	// --------------------------------------------------
	// Local parameters and signals.
	// --------------------------------------------------

	localparam int idx_nbits = $clog2(depth);

	decap_pkg::mem_state_e state;

	logic [decap_pkg::pio_nbits-1:0] mem [depth]; // Storage, not cleared by reset.

	logic [idx_nbits-1:0]            op_idx;  // Word index of the captured access.
	logic [decap_pkg::pio_nbits-1:0] op_data; // Write data of the captured access.

	logic req;     // Request aimed at this memory.
	logic pending; // An access waits for the tick.
	logic do_op;   // The access is carried out in this cycle.

	assign req = reg_bs & reg_ms & (reg_rd | reg_wr);

	assign pending = (state == decap_pkg::mem_pending_rd) ||
	                 (state == decap_pkg::mem_pending_wr);

	// A new request always wins over a pending tick. The master never
	// lines the two up in one cycle anyway.
	assign do_op = clk_div & pending & ~req;

	// --------------------------------------------------
	// Control state and acknowledge.
	// --------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= decap_pkg::mem_idle;
			mem_ack <= 1'b0;
		end else if (req) begin
			// A write takes priority if both pulses come together.
			if (reg_wr)
				state <= decap_pkg::mem_pending_wr;
			else
				state <= decap_pkg::mem_pending_rd;
			mem_ack <= 1'b0; // Drop the old ack right away.
		end else if (do_op) begin
			state   <= decap_pkg::mem_done;
			mem_ack <= 1'b1;
		end
	end

	// --------------------------------------------------
	// Request capture and memory access.
	// --------------------------------------------------

	// Only the low index bits are kept, so word addresses at or above
	// depth wrap around onto the same entries.
	always_ff @(posedge clk) begin
		if (req) begin
			op_idx  <= reg_addr[idx_nbits-1:0];
			op_data <= reg_din;
		end

		if (do_op) begin
			if (state == decap_pkg::mem_pending_wr) begin
				mem[op_idx] <= op_data;
				mem_rdata   <= op_data; // Reflect the written word.
			end else begin
				mem_rdata <= mem[op_idx];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/pio_clk_div.sv */
`timescale 1ns/10ps
`default_nettype none

// Enable strobe for the slow register side. The strobe is one clk cycle
// wide and repeats every clk_div_ratio cycles.
module pio_clk_div #(
	parameter int clk_div_ratio = 4
) (
	input  logic clk,
	input  logic rst_n,
	output logic clk_div
);

	// --------------------------------------------------
	// Local parameters and signals.
	// --------------------------------------------------

	localparam int cnt_nbits = $clog2(clk_div_ratio);
	localparam logic [cnt_nbits-1:0] cnt_last = cnt_nbits'(clk_div_ratio - 1);

	logic [cnt_nbits-1:0] cnt;
	logic                 cnt_wrap;

	assign cnt_wrap = (cnt == cnt_last); // Last count of one period.

	// --------------------------------------------------
	// Counter and strobe.
	// --------------------------------------------------

	// The counter starts at zero out of reset, so the first strobe is
	// registered at the clk_div_ratio-th edge after reset release.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt     <= '0;
			clk_div <= 1'b0;
		end else begin
			if (cnt_wrap)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			clk_div <= cnt_wrap; // High for exactly one cycle.
		end
	end

endmodule

`default_nettype wire

/* verilog/decap_pkg.sv */
`default_nettype none

package decap_pkg;

	// --------------------------------------------------
	// Register bus widths.
	// --------------------------------------------------

	localparam int pio_nbits = 32; // Data and address width of the PIO bus.

	// The memory-select field sits in the top nibble of the word address.
	localparam int decr_mem_sel_lsb   = 28;
	localparam int decr_mem_sel_nbits = 4;

	// --------------------------------------------------
	// Memory-select codes.
	// --------------------------------------------------

	// Codes 4 to 15 are unmapped and get the dummy acknowledge.
	typedef enum logic [decr_mem_sel_nbits-1:0] {
		decr_rci_hash_table  = 4'd0,
		decr_rci_value       = 4'd1,
		decr_ekey_hash_table = 4'd2,
		decr_ekey_value      = 4'd3
	} decr_mem_e;

	// --------------------------------------------------
	// Memory control state.
	// --------------------------------------------------

	// A memory sits in mem_done after its first access and only
	// leaves it when the next request arrives.
	typedef enum logic [1:0] {
		mem_idle       = 2'd0, // Nothing has happened since reset.
		mem_pending_rd = 2'd1, // Read captured, waiting for the tick.
		mem_pending_wr = 2'd2, // Write captured, waiting for the tick.
		mem_done       = 2'd3  // Access finished, ack is high.
	} mem_state_e;

endpackage

`default_nettype wire
